// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP      = reducer_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+tests
hw/reducer_pkg.sv
hw/fifo_ram.sv
hw/async_fifo.sv
hw/width_reducer.sv
hw/reducer_top.sv
tests/reducer_tb.sv

// File: hw/async_fifo.sv
module async_fifo (
  input  logic                       wr_clk,
  input  logic                       wr_resetn,
  input  logic                       rd_clk,
  input  logic                       rd_resetn,
  input  logic                       we,
  input  reducer_pkg::word_t         wdata,
  input  logic                       re,
  output reducer_pkg::word_t         rdata,
  output reducer_pkg::fifo_wr_stat_t wr_stat,
  output reducer_pkg::fifo_rd_stat_t rd_stat
);
  import reducer_pkg::*;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[FIFO_PTR_W-1] = gray[FIFO_PTR_W-1];
    for (int i = FIFO_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // Write side
  ptr_t wr_bin;
  ptr_t wr_gray;
  ptr_t rd_gray_w1;
  ptr_t rd_gray_w2;
  ptr_t rd_bin_w;
  ptr_t wr_used;
  logic [RST_CNT_W-1:0] wr_busy_cnt;
  logic wr_busy;
  logic wr_full;
  logic wr_ok;

  // Read side
  ptr_t rd_bin;
  ptr_t rd_gray;
  ptr_t wr_gray_r1;
  ptr_t wr_gray_r2;
  logic [RST_CNT_W-1:0] rd_busy_cnt;
  logic rd_busy;
  logic rd_empty;
  logic rd_ok;

  // Memory port wires
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;
  logic  rd_en;
  addr_t rd_addr;
  word_t rd_data;

  assign rd_bin_w = gray2bin(rd_gray_w2);
  assign wr_used  = wr_bin - rd_bin_w;
  assign wr_busy  = (wr_busy_cnt != '0);
  assign wr_full  = (wr_used >= ptr_t'(FIFO_DEPTH - FULL_MARGIN));
  // Hard stop at a truly full memory
  assign wr_ok    = we && !wr_busy && (wr_used != ptr_t'(FIFO_DEPTH));

  always_ff @(posedge wr_clk) begin
    if (!wr_resetn) begin
      wr_bin      <= '0;
      wr_gray     <= '0;
      rd_gray_w1  <= '0;
      rd_gray_w2  <= '0;
      wr_busy_cnt <= RST_CNT_W'(RST_BUSY_CYCLES);
    end else begin
      rd_gray_w1 <= rd_gray;       // Two-flop sync of read pointer
      rd_gray_w2 <= rd_gray_w1;
      if (wr_busy) begin
        wr_busy_cnt <= wr_busy_cnt - 1'b1;
      end
      if (wr_ok) begin
        wr_bin  <= ptr_t'(wr_bin + 1'b1);
        wr_gray <= bin2gray(ptr_t'(wr_bin + 1'b1));
      end
    end
  end

  assign rd_busy  = (rd_busy_cnt != '0);
  assign rd_empty = (rd_gray == wr_gray_r2);
  assign rd_ok    = re && !rd_empty && !rd_busy;

  always_ff @(posedge rd_clk) begin
    if (!rd_resetn) begin
      rd_bin      <= '0;
      rd_gray     <= '0;
      wr_gray_r1  <= '0;
      wr_gray_r2  <= '0;
      rd_busy_cnt <= RST_CNT_W'(RST_BUSY_CYCLES);
    end else begin
      wr_gray_r1 <= wr_gray;       // Two-flop sync of write pointer
      wr_gray_r2 <= wr_gray_r1;
      if (rd_busy) begin
        rd_busy_cnt <= rd_busy_cnt - 1'b1;
      end
      if (rd_ok) begin
        rd_bin  <= ptr_t'(rd_bin + 1'b1);
        rd_gray <= bin2gray(ptr_t'(rd_bin + 1'b1));
      end
    end
  end

  assign wr_en   = wr_ok;
  assign wr_addr = wr_bin[FIFO_ADDR_W-1:0];
  assign wr_data = wdata;
  assign rd_en   = rd_ok;
  assign rd_addr = rd_bin[FIFO_ADDR_W-1:0];
  assign rdata   = rd_data;

  assign wr_stat = '{full: wr_full, rst_busy: wr_busy};
  assign rd_stat = '{empty: rd_empty, rst_busy: rd_busy};

  fifo_ram u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// File: hw/fifo_ram.sv
module fifo_ram (
  input  logic               wr_clk,
  input  logic               wr_en,
  input  reducer_pkg::addr_t wr_addr,
  input  reducer_pkg::word_t wr_data,
  input  logic               rd_clk,
  input  logic               rd_en,
  input  reducer_pkg::addr_t rd_addr,
  output reducer_pkg::word_t rd_data
);
  import reducer_pkg::*;

  // Storage for the FIFO entries
  word_t mem [FIFO_DEPTH];

  // Write port
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read port, data one cycle after rd_en
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: hw/reducer_pkg.sv
package reducer_pkg;

  // Word and lane geometry
  localparam int WORD_W     = 128;
  localparam int LANE_W     = 64;
  localparam int LANES      = WORD_W / LANE_W;
  localparam int LANE_IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

  // FIFO geometry
  localparam int FIFO_DEPTH  = 16;
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_PTR_W  = FIFO_ADDR_W + 1;  // Extra wrap bit

  // Headroom for registered ready plus one write in flight
  localparam int FULL_MARGIN = 2;

  // Busy interval after reset, in cycles of each side's own clock
  localparam int RST_BUSY_CYCLES = 4;
  localparam int RST_CNT_W       = $clog2(RST_BUSY_CYCLES + 1);

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [LANE_W-1:0]      lane_t;
  typedef logic [FIFO_ADDR_W-1:0] addr_t;
  typedef logic [FIFO_PTR_W-1:0]  ptr_t;   // Binary or Gray

  // Write side status, WR_CLK domain
  typedef struct packed {
    logic full;
    logic rst_busy;
  } fifo_wr_stat_t;

  // Read side status, RD_CLK domain
  typedef struct packed {
    logic empty;
    logic rst_busy;
  } fifo_rd_stat_t;

  // One output beat
  typedef struct packed {
    lane_t data;
    logic  last;   // Highest lane of a word
  } lane_beat_t;

  // Read side sequencing of the reducer
  typedef enum logic [1:0] {
    IDLE,
    POP,
    SPLIT,
    DRAIN
  } red_state_t;

endpackage

// File: hw/reducer_top.sv
module reducer_top (
  input  logic                    wr_clk,
  input  logic                    wr_resetn,
  input  logic                    rd_clk,
  input  logic                    rd_resetn,
  input  logic                    din_valid,
  input  reducer_pkg::word_t      din,
  output logic                    convert_ready,
  input  logic                    module_ready,
  output reducer_pkg::lane_beat_t dout,
  output logic                    dout_valid
);
  import reducer_pkg::*;

  // Reducer to FIFO
  logic  fifo_we;
  word_t fifo_din;
  logic  fifo_re;
  word_t fifo_dout;

  // FIFO status, one struct per clock domain
  fifo_wr_stat_t wr_stat;
  fifo_rd_stat_t rd_stat;

  async_fifo u_fifo (
    .wr_clk    (wr_clk),
    .wr_resetn (wr_resetn),
    .rd_clk    (rd_clk),
    .rd_resetn (rd_resetn),
    .we        (fifo_we),
    .wdata     (fifo_din),
    .re        (fifo_re),
    .rdata     (fifo_dout),
    .wr_stat   (wr_stat),
    .rd_stat   (rd_stat)
  );

  width_reducer u_reducer (
    .wr_clk        (wr_clk),
    .wr_resetn     (wr_resetn),
    .rd_clk        (rd_clk),
    .rd_resetn     (rd_resetn),
    .din_valid     (din_valid),
    .din           (din),
    .fifo_we       (fifo_we),
    .fifo_din      (fifo_din),
    .wr_stat       (wr_stat),
    .convert_ready (convert_ready),
    .fifo_re       (fifo_re),
    .fifo_dout     (fifo_dout),
    .rd_stat       (rd_stat),
    .module_ready  (module_ready),
    .dout          (dout),
    .dout_valid    (dout_valid)
  );

endmodule

// File: hw/width_reducer.sv
module width_reducer (
  input  logic                       wr_clk,
  input  logic                       wr_resetn,
  input  logic                       rd_clk,
  input  logic                       rd_resetn,
  input  logic                       din_valid,
  input  reducer_pkg::word_t         din,
  output logic                       fifo_we,
  output reducer_pkg::word_t         fifo_din,
  input  reducer_pkg::fifo_wr_stat_t wr_stat,
  output logic                       convert_ready,
  output logic                       fifo_re,
  input  reducer_pkg::word_t         fifo_dout,
  input  reducer_pkg::fifo_rd_stat_t rd_stat,
  input  logic                       module_ready,
  output reducer_pkg::lane_beat_t    dout,
  output logic                       dout_valid
);
  import reducer_pkg::*;

  red_state_t state;
  logic [LANE_IDX_W-1:0] lane_cnt;
  logic read_ready;

  // Lane selection stage
  lane_beat_t sel_beat;
  logic       sel_valid;

  // Write side: one register stage for word, strobe and ready
  always_ff @(posedge wr_clk) begin
    if (!wr_resetn) begin
      fifo_we       <= 1'b0;
      convert_ready <= 1'b0;
    end else begin
      fifo_we       <= din_valid;
      convert_ready <= !wr_stat.full && !wr_stat.rst_busy;
    end
  end

  always_ff @(posedge wr_clk) begin
    fifo_din <= din;
  end

  // Gates only the start of a new word
  assign read_ready = !rd_stat.empty && module_ready && !rd_stat.rst_busy;

  // Pop, split and drain sequence
  always_ff @(posedge rd_clk) begin
    if (!rd_resetn) begin
      state    <= IDLE;
      lane_cnt <= '0;
      fifo_re  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (read_ready) begin
            fifo_re <= 1'b1;
            state   <= POP;
          end
        end
        POP: begin                        // Memory read under way
          fifo_re  <= 1'b0;
          lane_cnt <= '0;
          state    <= SPLIT;
        end
        SPLIT: begin
          lane_cnt <= lane_cnt + 1'b1;
          if (lane_cnt == LANE_IDX_W'(LANES - 2)) begin
            fifo_re <= read_ready;        // Next word lands after the top lane
            state   <= DRAIN;
          end
        end
        DRAIN: begin
          // Top lane selected this cycle
          fifo_re  <= 1'b0;
          lane_cnt <= '0;
          state    <= fifo_re ? SPLIT : IDLE;
        end
        default: begin
          fifo_re <= 1'b0;
          state   <= IDLE;
        end
      endcase
    end
  end

  // Lane select register
  always_ff @(posedge rd_clk) begin
    sel_beat.data <= fifo_dout[lane_cnt*LANE_W +: LANE_W];
    sel_beat.last <= (lane_cnt == LANE_IDX_W'(LANES - 1));
  end

  // Output register
  always_ff @(posedge rd_clk) begin
    dout <= sel_beat;
  end

  always_ff @(posedge rd_clk) begin
    if (!rd_resetn) begin
      sel_valid  <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      sel_valid  <= (state == SPLIT) || (state == DRAIN);
      dout_valid <= sel_valid;
    end
  end

endmodule

// File: tests/reducer_tb_checks.svh
`ifndef REDUCER_TB_CHECKS_SVH
`define REDUCER_TB_CHECKS_SVH

// Result counters
int    check_cnt;
int    error_cnt;
int    test_cnt;
int    test_checks;
int    test_errors;
string test_name;

task automatic report_error(input string msg);
  $display("Error in test %s: %s", test_name, msg);
  error_cnt++;
  test_errors++;
endtask

task automatic compare_lane(input string what, input lane_t exp, input lane_t act);
  check_cnt++;
  test_checks++;
  if (exp !== act) begin
    $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
    error_cnt++;
    test_errors++;
  end
endtask

task automatic compare_last(input string what, input logic exp, input logic act);
  check_cnt++;
  test_checks++;
  if (exp !== act) begin
    $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    error_cnt++;
    test_errors++;
  end
endtask

// Control and status outputs
task automatic compare_flag(input string what, input logic exp, input logic act);
  check_cnt++;
  test_checks++;
  if (exp !== act) begin
    $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
    error_cnt++;
    test_errors++;
  end
endtask

task automatic start_test(input string name);
  test_name   = name;
  test_checks = 0;
  test_errors = 0;
endtask

task automatic end_test();
  test_cnt++;
  $display("Test %-12s %s: %0d checks, %0d errors", test_name,
           (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
endtask

task automatic print_summary();
  $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, error_cnt);
endtask

`endif

// File: tests/reducer_tb.sv
module reducer_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import reducer_pkg::*;

  localparam int RD_PERIOD    = 4;
  localparam int WR_PERIOD    = 6;
  localparam int SINGLE_WORDS = 4;
  localparam int STREAM_WORDS = 40;
  localparam int TOGGLE_WORDS = 40;
  localparam int TOTAL_WORDS  = SINGLE_WORDS + STREAM_WORDS + FIFO_DEPTH + TOGGLE_WORDS;
  localparam int WATCHDOG_NS  = TOTAL_WORDS * LANES * 20 * RD_PERIOD + 2000;
  localparam logic [31:0] LFSR_SEED = 32'hd619fd3f;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic       wr_clk;
  logic       rd_clk;
  logic       wr_resetn;
  logic       rd_resetn;
  logic       din_valid;
  word_t      din;
  logic       convert_ready;
  logic       module_ready;
  lane_beat_t dout;
  logic       dout_valid;

  lane_beat_t  exp_q[$];    // Expected beats in arrival order
  lane_beat_t  exp_beat;
  logic [31:0] lfsr_state;
  logic        mid_word;    // Previous beat was not the top lane
  logic        sending_done;
  int          beat_cnt;
  int          fill_cnt;
  word_t       toggle_words [TOGGLE_WORDS];

  `include "reducer_tb_checks.svh"

  reducer_top DUT (
    .wr_clk        (wr_clk),
    .wr_resetn     (wr_resetn),
    .rd_clk        (rd_clk),
    .rd_resetn     (rd_resetn),
    .din_valid     (din_valid),
    .din           (din),
    .convert_ready (convert_ready),
    .module_ready  (module_ready),
    .dout          (dout),
    .dout_valid    (dout_valid)
  );

  always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
  always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic next_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic word_t random_word();
    word_t w;
    for (int i = 0; i < WORD_W; i++) begin
      w[i] = next_bit();
    end
    return w;
  endfunction

  // Lane i is the i-th LANE_W slice with last only on the top lane
  function automatic lane_beat_t ref_beat(input word_t w, input int lane);
    lane_beat_t b;
    b.data = w[lane*LANE_W +: LANE_W];
    b.last = (lane == LANES - 1);
    return b;
  endfunction

  task automatic send_word(input word_t w);
    @(negedge wr_clk);
    while (!convert_ready) begin
      din_valid = 1'b0;
      @(negedge wr_clk);
    end
    din_valid = 1'b1;
    din       = w;
    for (int i = 0; i < LANES; i++) begin
      exp_q.push_back(ref_beat(w, i));
    end
  endtask

  task automatic stop_writing();
    @(negedge wr_clk);
    din_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge rd_clk);
    end
    @(negedge rd_clk);
    compare_flag("dout_valid after last lane", 1'b0, dout_valid);
  endtask

  task automatic wait_convert_ready();
    int n;
    n = 0;
    while (!convert_ready && n < 2 * RST_BUSY_CYCLES) begin
      @(negedge wr_clk);
      n++;
    end
    if (!convert_ready) report_error("convert_ready never rose after the reset busy interval");
  endtask

  // Compare every output beat against the reference queue
  always @(negedge rd_clk) begin
    if (!rd_resetn) begin
      mid_word = 1'b0;
    end else if (dout_valid) begin
      beat_cnt++;
      if (exp_q.size() == 0) begin
        report_error("output beat arrived with no word outstanding");
      end else begin
        exp_beat = exp_q.pop_front();
        compare_lane("lane data", exp_beat.data, dout.data);
        compare_last("last flag", exp_beat.last, dout.last);
      end
      mid_word = !dout.last;
    end else begin
      if (mid_word) report_error("dout_valid dropped in the middle of a word");
      mid_word = 1'b0;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    wr_clk       = 1'b0;
    rd_clk       = 1'b0;
    wr_resetn    = 1'b0;
    rd_resetn    = 1'b0;
    din_valid    = 1'b0;
    din          = '0;
    module_ready = 1'b0;
    lfsr_state   = LFSR_SEED;
    mid_word     = 1'b0;
    sending_done = 1'b0;
    fork
      begin
        repeat (3) @(negedge wr_clk);
        wr_resetn = 1'b1;
      end
      begin
        repeat (3) @(negedge rd_clk);
        rd_resetn = 1'b1;
      end
    join

    start_test("reset");
    @(negedge rd_clk);
    compare_flag("dout_valid after reset", 1'b0, dout_valid);
    for (int i = 0; i < RST_BUSY_CYCLES; i++) begin
      @(negedge wr_clk);
      compare_flag("convert_ready while busy", 1'b0, convert_ready);
    end
    wait_convert_ready();
    end_test();

    start_test("single");
    @(negedge rd_clk) module_ready = 1'b1;
    for (int i = 0; i < SINGLE_WORDS; i++) begin
      send_word(random_word());
      stop_writing();
      wait_drained();
      repeat (5) @(negedge rd_clk);  // Idle gap
    end
    end_test();

    start_test("stream");
    for (int i = 0; i < STREAM_WORDS; i++) begin
      send_word(random_word());
    end
    stop_writing();
    wait_drained();
    end_test();

    start_test("backpressure");
    @(negedge rd_clk) module_ready = 1'b0;
    beat_cnt = 0;
    fill_cnt = 0;
    @(negedge wr_clk);
    while (convert_ready) begin
      din_valid = 1'b1;
      din       = random_word();
      for (int i = 0; i < LANES; i++) begin
        exp_q.push_back(ref_beat(din, i));
      end
      fill_cnt++;
      @(negedge wr_clk);
    end
    din_valid = 1'b0;
    repeat (20) @(posedge rd_clk);
    if (beat_cnt != 0) report_error("beats came out while module_ready was low");
    if (fill_cnt < FIFO_DEPTH - FULL_MARGIN || fill_cnt > FIFO_DEPTH)
      report_error($sformatf("FIFO took %0d words before convert_ready fell", fill_cnt));
    @(negedge rd_clk) module_ready = 1'b1;
    wait_drained();
    end_test();

    start_test("toggle");
    // Words drawn up front so the ready pattern owns the LFSR during streaming
    for (int i = 0; i < TOGGLE_WORDS; i++) begin
      toggle_words[i] = random_word();
    end
    fork
      begin
        for (int i = 0; i < TOGGLE_WORDS; i++) begin
          send_word(toggle_words[i]);
        end
        stop_writing();
        sending_done = 1'b1;
      end
      begin
        while (!sending_done) begin
          @(negedge rd_clk);
          module_ready = next_bit();
        end
      end
    join
    @(negedge rd_clk) module_ready = 1'b1;
    wait_drained();
    end_test();

    print_summary();
    if (error_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
